// ==== bench/mainboard_props.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module mainboard_props (
   input logic                     clk,
   input logic                     reset_i,
   input mainboard_pkg::cpu_bus_t  cpu_i,
   input logic                     byte_side_i,
   input logic [15:0]              read_data_o,
   input logic                     ready_o,
   input logic                     cpu_clk_en_o,
   input mainboard_pkg::host_req_t host_i,
   input logic                     rom_stb_i,
   input logic                     cart_stb_i,
   input logic                     host_ack_o
);

   int unsigned prop_failures = 0;   // read by the testbench at the end

   // a mapped request is acknowledged on the next clock
   host_ack_timing: assert property (@(posedge clk) disable iff (reset_i)
      (rom_stb_i || cart_stb_i) && host_i.cyc && !host_ack_o |=> host_ack_o)
      else begin
         $error("host ack missing one clock after a mapped request");
         prop_failures++;
      end

   cpu_enable_spacing: assert property (@(posedge clk) disable iff (reset_i)
      cpu_clk_en_o |=> !cpu_clk_en_o [*(`CPU_CLK_DIV - 1)] ##1 cpu_clk_en_o)
      else begin
         $error("cpu clock enable pulses are not evenly spaced");
         prop_failures++;
      end

   ready_falls_at_start: assert property (@(posedge clk) disable iff (reset_i)
      $fell(ready_o) |-> $past(cpu_clk_en_o && cpu_i.memen && byte_side_i))
      else begin
         $error("ready dropped outside a byte-side start tick");
         prop_failures++;
      end

   ready_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> ready_o)
      else begin
         $error("ready low right after reset");
         prop_failures++;
      end

   // nothing drives the read bus once the cycle is over
   idle_read_bus: assert property (@(posedge clk) disable iff (reset_i)
      !cpu_i.memen |=> read_data_o == 16'h0000)
      else begin
         $error("read bus not zero without a cpu cycle");
         prop_failures++;
      end

endmodule

// ==== bench/mainboard_tb.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module mainboard_tb;

   localparam int TIMEOUT_CYCLES = 20000;

   logic                     clk;
   logic                     reset_i;
   mainboard_pkg::cpu_bus_t  cpu_i;
   mainboard_pkg::host_req_t host_i;
   logic [15:0]              read_data_o;
   logic                     ready_o;
   logic                     cpu_clk_en_o;
   logic [7:0]               host_dat_o;
   logic                     host_ack_o;

   logic [31:0] lfsr = 32'h0f84703b;
   int          errors = 0;
   int          cycles = 0;
   logic [7:0]  rom_ref [16];
   logic [7:0]  cart_ref [`CROM_BANKS][16];
   logic [15:0] ram_ref [128];
   logic [8:0]  ram_addr [16];

   mainboard mainboard_i (.*);

   bind mainboard mainboard_props props_i (
      .clk(clk), .reset_i(reset_i), .cpu_i(cpu_i), .byte_side_i(region.byte_side),
      .read_data_o(read_data_o), .ready_o(ready_o), .cpu_clk_en_o(cpu_clk_en_o),
      .host_i(host_i), .rom_stb_i(rom_stb), .cart_stb_i(cart_stb), .host_ack_o(host_ack_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic check_value(string what, logic [15:0] got, logic [15:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // starts at a cpu tick, waits out ready, then ends the cycle
   task automatic cpu_access(logic we, logic [14:0] addr, logic [15:0] wdata,
                             output logic [15:0] rdata, output logic rdy);
      @(negedge clk);
      while (!cpu_clk_en_o) @(negedge clk);
      @(posedge clk);
      cpu_i <= '{memen: 1'b1, we: we, dbin: !we, addr: addr, wdata: wdata};
      repeat (`CPU_CLK_DIV) @(posedge clk);
      @(negedge clk);
      rdy = ready_o;
      while (!ready_o) @(negedge clk);
      rdata = read_data_o;
      @(posedge clk);
      cpu_i <= '0;
   endtask

   task automatic host_access(logic we, logic [23:0] addr, logic [7:0] data, int max_wait,
                              output logic [7:0] rdata, output logic acked);
      acked = 1'b0;
      rdata = 8'h00;
      @(posedge clk);
      host_i <= '{addr: addr, data: data, we: we, stb: 1'b1, cyc: 1'b1};
      for (int i = 0; i < max_wait && !acked; i++) begin
         @(negedge clk);
         if (host_ack_o) begin
            acked = 1'b1;
            rdata = host_dat_o;
         end
      end
      @(posedge clk);
      host_i <= '0;
      @(posedge clk);   // stb low for a clock
   endtask

   initial begin
      logic [15:0] rd;
      logic [7:0]  hd;
      logic        ok;
      int          bank;
      int          pf;
      cpu_i = '0;
      host_i = '0;
      reset_i = 1'b1;
      repeat (10) @(posedge clk);
      reset_i <= 1'b0;

      for (int b = 0; b < 16; b++) begin   // console rom load, even byte is the high byte
         rom_ref[b] = 8'(rand_bits(8));
         host_access(1'b1, 24'(b), rom_ref[b], 4, hd, ok);
         check_value("console rom load ack", 16'(ok), 16'h0001);
      end
      for (int w = 0; w < 8; w++) begin
         cpu_access(1'b0, 15'(w), 16'h0000, rd, ok);
         check_value("console rom word", rd, {rom_ref[2*w], rom_ref[2*w+1]});
      end
      for (int b = 0; b < 16; b++) begin
         host_access(1'b0, 24'(b), 8'h00, 4, hd, ok);
         check_value("console rom host byte", {7'd0, ok, hd}, {8'h01, rom_ref[b]});
      end

      for (int k = 0; k < `CROM_BANKS; k++) begin
         for (int b = 0; b < 16; b++) begin
            cart_ref[k][b] = 8'(rand_bits(8));
            host_access(1'b1, {1'b1, 10'(k), 13'(b)}, cart_ref[k][b], 4, hd, ok);
            check_value("cartridge load ack", 16'(ok), 16'h0001);
         end
      end
      for (int w = 0; w < 8; w++) begin
         cpu_access(1'b0, {3'd3, 12'(w)}, 16'h0000, rd, ok);
         check_value("cartridge ready low", 16'(ok), 16'h0000);
         check_value("cartridge bank 0 word", rd, {cart_ref[0][2*w], cart_ref[0][2*w+1]});
      end

      for (int n = 0; n < 5; n++) begin   // bank select writes, 6 wraps around
         bank = (n == 4) ? 6 : n + 1;
         cpu_access(1'b1, {3'd3, 12'(bank)}, 16'(rand_bits(16)), rd, ok);
         bank = bank % `CROM_BANKS;
         for (int w = 0; w < 4; w++) begin
            cpu_access(1'b0, {3'd3, 12'(w)}, 16'h0000, rd, ok);
            check_value("banked cartridge word", rd,
                        {cart_ref[bank][2*w], cart_ref[bank][2*w+1]});
         end
      end

      for (int n = 0; n < 16; n++) begin
         ram_addr[n] = 9'(rand_bits(9));
         ram_ref[ram_addr[n][6:0]] = 16'(rand_bits(16));
         cpu_access(1'b1, {6'b100000, ram_addr[n]}, ram_ref[ram_addr[n][6:0]], rd, ok);
      end
      for (int n = 0; n < 16; n++) begin   // read back through another mirror
         cpu_access(1'b0, {6'b100000, ~ram_addr[n][8:7], ram_addr[n][6:0]}, 16'h0000, rd, ok);
         check_value("scratchpad word", rd, ram_ref[ram_addr[n][6:0]]);
      end

      cpu_access(1'b0, 15'h2000, 16'h0000, rd, ok);
      check_value("unmapped cpu ready", 16'(ok), 16'h0001);
      check_value("unmapped cpu read", rd, 16'h0000);
      cpu_access(1'b0, 15'h5000, 16'h0000, rd, ok);
      check_value("unmapped cpu ready", 16'(ok), 16'h0001);
      check_value("unmapped cpu read", rd, 16'h0000);
      host_access(1'b0, 24'h004000, 8'h00, 8, hd, ok);
      check_value("unmapped host ack", 16'(ok), 16'h0000);
      host_access(1'b1, 24'h80a000, 8'h5a, 8, hd, ok);
      check_value("unmapped host ack", 16'(ok), 16'h0000);

      pf = int'(mainboard_i.props_i.prop_failures);
      $display("value errors: %0d, property failures: %0d", errors, pf);
      if (errors == 0 && pf == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+source
source/mainboard_pkg.sv
source/clock_enables.sv
source/address_decoder.sv
source/byte_multiplexer.sv
source/scratchpad_ram.sv
source/console_rom.sv
source/cartridge_rom.sv
source/host_router.sv
source/mainboard.sv
bench/mainboard_props.sv
bench/mainboard_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mainboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module mainboard_tb \
   -o mainboard_sim

# raise the error limit so assertion failures reach the closing line
out=$(./obj_dir/mainboard_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "^Simulation passed$"

// ==== source/address_decoder.sv ====
`timescale 1ns/1ps

module address_decoder (
   input  mainboard_pkg::cpu_bus_t cpu_i,
   output mainboard_pkg::region_t  region_o
);

   // windows on the word address, byte address is {addr, a15}
   localparam logic [2:0] ROM_WIN     = 3'd0;       // 0000-1fff
   localparam logic [2:0] CART_WIN    = 3'd3;       // 6000-7fff
   localparam logic [5:0] SCRATCH_WIN = 6'b100000;  // 8000-83ff

   logic rom_hit;
   logic cart_hit;
   logic scratch_hit;

   assign rom_hit     = (cpu_i.addr[14:12] == ROM_WIN);
   assign cart_hit    = (cpu_i.addr[14:12] == CART_WIN);
   assign scratch_hit = (cpu_i.addr[14:9] == SCRATCH_WIN);

   always_comb begin
      region_o = '0;
      if (cpu_i.memen) begin
         region_o.rom_sel     = rom_hit;
         region_o.scratch_sel = scratch_hit;
         region_o.cart_sel    = cart_hit;
         // only the cartridge lives on the 8-bit side here
         region_o.byte_side   = cart_hit;
      end
   end

endmodule

// ==== source/byte_multiplexer.sv ====
`timescale 1ns/1ps

module byte_multiplexer (
   input  logic                      clk,
   input  logic                      reset_i,
   input  logic                      cpu_clk_en_i,
   input  mainboard_pkg::cpu_bus_t   cpu_i,
   input  logic                      byte_side_i,
   output mainboard_pkg::byte_bus_t  byte_o,
   input  logic [7:0]                byte_rdata_i,
   output logic [15:0]               word_o,
   output logic                      word_valid_o,
   output logic                      ready_o
);

   typedef enum logic [1:0] {S_IDLE, S_LOW, S_HIGH, S_DONE} state_t;

   state_t state;
   logic   half;          // set on the second tick of a phase
   logic   phase_end;

   assign phase_end = cpu_clk_en_i && half;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= S_IDLE;
         half <= 1'b0;
         ready_o <= 1'b1;
         word_valid_o <= 1'b0;
         byte_o <= '0;
      end else begin
         if (cpu_clk_en_i && (state == S_LOW || state == S_HIGH))
            half <= ~half;
         case (state)
            S_IDLE: begin
               if (cpu_clk_en_i && cpu_i.memen && byte_side_i) begin
                  state <= S_LOW;
                  half <= 1'b0;
                  ready_o <= 1'b0;
                  byte_o.sel <= 1'b1;
                  byte_o.we <= cpu_i.we;
                  byte_o.rd <= cpu_i.dbin;
                  byte_o.addr <= {cpu_i.addr[11:0], 1'b1};   // low byte first
                  byte_o.wdata <= cpu_i.wdata[7:0];
               end
            end
            S_LOW: begin
               if (phase_end) begin
                  state <= S_HIGH;
                  byte_o.addr[0] <= 1'b0;
                  byte_o.wdata <= cpu_i.wdata[15:8];
               end
            end
            S_HIGH: begin
               if (phase_end) begin
                  state <= S_DONE;
                  ready_o <= 1'b1;
                  word_valid_o <= cpu_i.dbin;
                  byte_o.sel <= 1'b0;
                  byte_o.we <= 1'b0;
                  byte_o.rd <= 1'b0;
               end
            end
            S_DONE: begin
               if (!cpu_i.memen) begin   // hold the word until the cycle ends
                  state <= S_IDLE;
                  word_valid_o <= 1'b0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // byte capture at the end of each phase
   always_ff @(posedge clk) begin
      if (phase_end && state == S_LOW)
         word_o[7:0] <= byte_rdata_i;
      if (phase_end && state == S_HIGH)
         word_o[15:8] <= byte_rdata_i;
   end

endmodule

// ==== source/cartridge_rom.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module cartridge_rom #(
   parameter int BANKS = `CROM_BANKS
) (
   input  logic                     clk,
   input  logic                     reset_i,
   input  mainboard_pkg::byte_bus_t byte_i,
   output logic [7:0]               rdata_o,
   input  mainboard_pkg::host_req_t host_i,
   input  logic                     host_stb_i,
   output logic [7:0]               host_dat_o,
   output logic                     host_ack_o
);

   localparam int BANK_W = (BANKS > 1) ? $clog2(BANKS) : 1;
   localparam int FLAT_W = BANK_W + 13;

   logic [7:0]        mem [BANKS * 8192];
   logic [BANK_W-1:0] bank;
   logic [FLAT_W-1:0] cpu_index;
   logic [FLAT_W-1:0] host_index;
   logic              host_go;

   assign cpu_index  = {bank, byte_i.addr};
   assign host_index = host_i.addr[FLAT_W-1:0];   // bank * 8K + offset
   assign host_go    = host_stb_i && host_i.cyc && !host_ack_o;

   // a cpu write selects the bank, data is ignored
   always_ff @(posedge clk) begin
      if (reset_i)
         bank <= '0;
      else if (byte_i.sel && byte_i.we)
         bank <= BANK_W'(byte_i.addr[12:1] % BANKS);
   end

   always_ff @(posedge clk) begin
      if (byte_i.sel && byte_i.rd)
         rdata_o <= mem[cpu_index];
   end

   always_ff @(posedge clk) begin
      if (host_go) begin
         if (host_i.we)
            mem[host_index] <= host_i.data;
         host_dat_o <= mem[host_index];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i)
         host_ack_o <= 1'b0;
      else
         host_ack_o <= host_go;
   end

endmodule

// ==== source/clock_enables.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module clock_enables (
   input  logic clk,
   input  logic reset_i,
   output logic cpu_clk_en_o
);

   localparam int CNT_W = $clog2(`CPU_CLK_DIV + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CPU_CLK_DIV - 1);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         count <= '0;
         cpu_clk_en_o <= 1'b0;
      end else begin
         cpu_clk_en_o <= (count == CNT_LAST);   // one pulse per wrap
         if (count == CNT_LAST)
            count <= '0;
         else
            count <= count + 1'b1;
      end
   end

endmodule

// ==== source/console_rom.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module console_rom (
   input  logic                     clk,
   input  logic                     reset_i,
   input  logic                     sel_i,
   input  logic [11:0]              addr_i,
   output logic [15:0]              rdata_o,
   input  mainboard_pkg::host_req_t host_i,
   input  logic                     host_stb_i,
   output logic [7:0]               host_dat_o,
   output logic                     host_ack_o
);

   logic [15:0] mem [`ROM_WORDS];
   logic [11:0] host_word;
   logic        host_lo;       // odd byte address holds bits 7:0
   logic        host_go;

   assign host_word = host_i.addr[12:1];
   assign host_lo   = host_i.addr[0];
   assign host_go   = host_stb_i && host_i.cyc && !host_ack_o;

   always_ff @(posedge clk) begin
      if (sel_i)
         rdata_o <= mem[addr_i];
   end

   always_ff @(posedge clk) begin
      if (host_go) begin
         if (host_i.we) begin
            if (host_lo)
               mem[host_word][7:0] <= host_i.data;
            else
               mem[host_word][15:8] <= host_i.data;
         end
         host_dat_o <= host_lo ? mem[host_word][7:0] : mem[host_word][15:8];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i)
         host_ack_o <= 1'b0;
      else
         host_ack_o <= host_go;   // single clock ack
   end

endmodule

// ==== source/host_router.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module host_router (
   input  mainboard_pkg::host_req_t host_i,
   output logic                     rom_stb_o,
   output logic                     cart_stb_o,
   input  logic [7:0]               rom_dat_i,
   input  logic                     rom_ack_i,
   input  logic [7:0]               cart_dat_i,
   input  logic                     cart_ack_i,
   output logic [7:0]               host_dat_o,
   output logic                     host_ack_o
);

   logic rom_hit;
   logic cart_hit;

   // bit 23 picks the cartridge, bits 22:13 are the 8K bank number
   assign cart_hit = host_i.addr[23] && (host_i.addr[22:13] < 10'(`CROM_BANKS));
   assign rom_hit  = !host_i.addr[23] && (host_i.addr[22:13] == '0);

   always_comb begin
      rom_stb_o  = 1'b0;
      cart_stb_o = 1'b0;
      host_dat_o = 8'h00;
      host_ack_o = 1'b0;
      if (cart_hit) begin
         cart_stb_o = host_i.stb;
         host_dat_o = cart_dat_i;
         host_ack_o = cart_ack_i;
      end else if (rom_hit) begin
         rom_stb_o  = host_i.stb;
         host_dat_o = rom_dat_i;
         host_ack_o = rom_ack_i;
      end
   end

endmodule

// ==== source/mainboard.sv ====
`timescale 1ns/1ps

module mainboard (
   input  logic                     clk,
   input  logic                     reset_i,
   input  mainboard_pkg::cpu_bus_t  cpu_i,
   output logic [15:0]              read_data_o,
   output logic                     ready_o,
   output logic                     cpu_clk_en_o,
   input  mainboard_pkg::host_req_t host_i,
   output logic [7:0]               host_dat_o,
   output logic                     host_ack_o
);

   mainboard_pkg::region_t   region;
   mainboard_pkg::byte_bus_t byte_bus;

   logic [15:0] rom_rdata;
   logic [15:0] scratch_rdata;
   logic [15:0] mux_word;
   logic        mux_valid;
   logic [7:0]  cart_rdata;
   logic        rom_valid;
   logic        scratch_valid;

   logic        rom_stb;
   logic        cart_stb;
   logic [7:0]  rom_host_dat;
   logic [7:0]  cart_host_dat;
   logic        rom_host_ack;
   logic        cart_host_ack;

   // 16-bit sources present data one clock after the request
   always_ff @(posedge clk) begin
      if (reset_i) begin
         rom_valid <= 1'b0;
         scratch_valid <= 1'b0;
      end else begin
         rom_valid <= cpu_i.dbin && region.rom_sel;
         scratch_valid <= cpu_i.dbin && region.scratch_sel;
      end
   end

   assign read_data_o = (rom_valid     ? rom_rdata     : 16'h0000) |
                        (scratch_valid ? scratch_rdata : 16'h0000) |
                        (mux_valid     ? mux_word      : 16'h0000);

   clock_enables clk_en_i (.clk(clk), .reset_i(reset_i), .cpu_clk_en_o(cpu_clk_en_o));

   address_decoder addr_dec_i (.cpu_i(cpu_i), .region_o(region));

   byte_multiplexer mpx_i (
      .clk(clk), .reset_i(reset_i), .cpu_clk_en_i(cpu_clk_en_o),
      .cpu_i(cpu_i), .byte_side_i(region.byte_side),
      .byte_o(byte_bus), .byte_rdata_i(cart_rdata),
      .word_o(mux_word), .word_valid_o(mux_valid), .ready_o(ready_o)
   );

   scratchpad_ram ram_i (
      .clk(clk), .sel_i(region.scratch_sel), .we_i(cpu_i.we),
      .addr_i(cpu_i.addr[6:0]), .wdata_i(cpu_i.wdata), .rdata_o(scratch_rdata)
   );

   console_rom rom_i (
      .clk(clk), .reset_i(reset_i), .sel_i(region.rom_sel),
      .addr_i(cpu_i.addr[11:0]), .rdata_o(rom_rdata),
      .host_i(host_i), .host_stb_i(rom_stb),
      .host_dat_o(rom_host_dat), .host_ack_o(rom_host_ack)
   );

   cartridge_rom crom_i (
      .clk(clk), .reset_i(reset_i), .byte_i(byte_bus), .rdata_o(cart_rdata),
      .host_i(host_i), .host_stb_i(cart_stb),
      .host_dat_o(cart_host_dat), .host_ack_o(cart_host_ack)
   );

   host_router router_i (
      .host_i(host_i), .rom_stb_o(rom_stb), .cart_stb_o(cart_stb),
      .rom_dat_i(rom_host_dat), .rom_ack_i(rom_host_ack),
      .cart_dat_i(cart_host_dat), .cart_ack_i(cart_host_ack),
      .host_dat_o(host_dat_o), .host_ack_o(host_ack_o)
   );

endmodule

// ==== source/mainboard_defines.svh ====
`ifndef MAINBOARD_DEFINES_SVH
`define MAINBOARD_DEFINES_SVH

// system clocks per cpu clock enable pulse
`define CPU_CLK_DIV 4

// number of 8K cartridge banks
`define CROM_BANKS 4

// scratchpad depth in 16-bit words
`define SCRATCH_WORDS 128

// console rom depth in 16-bit words
`define ROM_WORDS 4096

`endif

// ==== source/mainboard_pkg.sv ====
package mainboard_pkg;

   // cpu side strobes, word address excludes a15
   typedef struct packed {
      logic        memen;
      logic        we;
      logic        dbin;
      logic [14:0] addr;
      logic [15:0] wdata;
   } cpu_bus_t;

   typedef struct packed {
      logic rom_sel;
      logic scratch_sel;
      logic cart_sel;
      logic byte_side;   // access goes through the byte multiplexer
   } region_t;

   // 8-bit peripheral side, addr[0] is a15
   typedef struct packed {
      logic        sel;
      logic        we;
      logic        rd;
      logic [12:0] addr;
      logic [7:0]  wdata;
   } byte_bus_t;

   typedef struct packed {
      logic [23:0] addr;
      logic [7:0]  data;
      logic        we;
      logic        stb;
      logic        cyc;
   } host_req_t;

endpackage

// ==== source/scratchpad_ram.sv ====
`timescale 1ns/1ps
`include "mainboard_defines.svh"

module scratchpad_ram (
   input  logic        clk,
   input  logic        sel_i,
   input  logic        we_i,
   input  logic [6:0]  addr_i,
   input  logic [15:0] wdata_i,
   output logic [15:0] rdata_o
);

   logic [15:0] mem [`SCRATCH_WORDS];

   always_ff @(posedge clk) begin
      if (sel_i) begin
         if (we_i)
            mem[addr_i] <= wdata_i;
         rdata_o <= mem[addr_i];   // read old data on a write cycle
      end
   end

endmodule
